//--- sources.f
rtl/tile_bus_pkg.sv
rtl/tile_sfr_pkg.sv
rtl/host_decode.sv
rtl/tile_ram.sv
rtl/tile_sfr.sv
rtl/irq_adapter.sv
rtl/sigma_tile.sv
verification/tile_props.sv
verification/tb_sigma_tile.sv

//--- verification/tb_sigma_tile.sv
// sigma tile testbench
// random host traffic to RAM and SFRs, interrupt edges, SGIs, timer
// and software reset, all checked against a model of the tile

`timescale 1ns/1ps

module tb_sigma_tile
    import tile_bus_pkg::*;
    import tile_sfr_pkg::*;
();

    localparam int    MEM_SIZE    = 1024;
    localparam int    CORE_ID     = 3;
    localparam int    IRQ_NUM_POW = 4;
    localparam int    IRQ_NUM     = 2**IRQ_NUM_POW;
    localparam int    RAM_WORDS   = 64;
    localparam addr_t SFR_BASE    = addr_t'(1) << SFR_BITSEL;

    logic                   clk_i;
    logic                   rst_i;
    logic                   req_i;
    logic                   we_i;
    addr_t                  addr_i;
    be_t                    be_i;
    data_t                  wdata_i;
    logic                   ack_o;
    data_t                  rdata_o;
    logic [IRQ_NUM-1:0]     irq_i;
    logic                   irq_ack_i;
    logic                   irq_req_o;
    logic [IRQ_NUM_POW-1:0] irq_code_o;

    data_t              ram_model [RAM_WORDS];
    logic [IRQ_NUM-1:0] en_model;

    sigma_tile #(
        .MEM_SIZE           (MEM_SIZE)
        , .CORENUM          (CORE_ID)
        , .SW_RESET_DEFAULT (1'b0)
        , .IRQ_NUM_POW      (IRQ_NUM_POW)
    ) i_dut (
        .clk_i          (clk_i)
        , .rst_i        (rst_i)
        , .req_i        (req_i)
        , .we_i         (we_i)
        , .addr_i       (addr_i)
        , .be_i         (be_i)
        , .wdata_i      (wdata_i)
        , .ack_o        (ack_o)
        , .rdata_o      (rdata_o)
        , .irq_i        (irq_i)
        , .irq_req_o    (irq_req_o)
        , .irq_code_o   (irq_code_o)
        , .irq_ack_i    (irq_ack_i)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input be_t be);
        data_t res;
        res = old_word;
        for (int b = 0; b < 4; b++)
            if (be[b])
                res[b*8 +: 8] = new_word[b*8 +: 8];
        return res;
    endfunction

    task automatic host_access(input logic we, input addr_t addr, input be_t be,
                               input data_t wdata, output data_t rdata);
        int cnt;
        int hold;
        @(posedge clk_i);
        #1;
        req_i   = 1'b1;
        we_i    = we;
        addr_i  = addr;
        be_i    = be;
        wdata_i = wdata;
        cnt = 0;
        while (!ack_o)
        begin
            @(posedge clk_i);
            #1;
            cnt++;
            if (cnt > 10)
                stop_run("no ack_o from the tile for a host request");
        end
        check_value("ack_o latency", cnt, 3);
        rdata = rdata_o;
        // ack and data hold under back-pressure
        hold = $urandom % 4;
        repeat (hold)
        begin
            @(posedge clk_i);
            #1;
            check_value("ack_o held", ack_o, 1);
            check_value("rdata_o held", rdata_o, rdata);
        end
        req_i = 1'b0;
        cnt = 0;
        while (ack_o)
        begin
            @(posedge clk_i);
            #1;
            cnt++;
            if (cnt > 10)
                stop_run("ack_o stayed high after req_i dropped");
        end
        check_value("ack_o release", cnt, 2);
    endtask

    task automatic sfr_write(input sfr_idx_t idx, input data_t data);
        data_t unused;
        host_access(1'b1, SFR_BASE | addr_t'(idx) << 2, 4'hF, data, unused);
    endtask

    task automatic sfr_read(input sfr_idx_t idx, output data_t data);
        host_access(1'b0, SFR_BASE | addr_t'(idx) << 2, 4'hF, '0, data);
    endtask

    // acts as the core, answers one request if it comes within limit cycles
    task automatic take_irq(input int limit, output logic got,
                            output logic [IRQ_NUM_POW-1:0] code);
        int cnt;
        cnt  = 0;
        got  = 1'b0;
        code = '0;
        while (!irq_req_o && cnt < limit)
        begin
            @(posedge clk_i);
            #1;
            cnt++;
        end
        if (irq_req_o)
        begin
            got       = 1'b1;
            code      = irq_code_o;
            irq_ack_i = 1'b1;
            cnt = 0;
            while (irq_req_o)
            begin
                @(posedge clk_i);
                #1;
                cnt++;
                if (cnt > 8)
                    stop_run("irq_req_o stayed high after irq_ack_i");
            end
            irq_ack_i = 1'b0;
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic pulse_lines(input logic [IRQ_NUM-1:0] lines);
        @(posedge clk_i);
        #1;
        irq_i = lines;
        repeat (2) @(posedge clk_i);
        #1;
        irq_i = '0;
    endtask

    // lowest index first, each enabled edge exactly once
    task automatic edge_round(input logic [IRQ_NUM-1:0] edges);
        int                     expect_q[$];
        logic                   got;
        logic [IRQ_NUM_POW-1:0] code;
        for (int i = 0; i < IRQ_NUM; i++)
            if (edges[i] && en_model[i])
                expect_q.push_back(i);
        pulse_lines(edges);
        foreach (expect_q[k])
        begin
            take_irq(30, got, code);
            check_value("irq_req_o delivered", got, 1);
            check_value("irq_code_o", code, expect_q[k]);
        end
        take_irq(30, got, code);
        check_value("irq_req_o extra", got, 0);
    endtask

    always @(posedge clk_i)
    begin
        if (i_dut.i_props.fail_count != 0)
            stop_run("a handshake assertion on the tile failed");
    end

    initial
    begin
        data_t                  rd;
        data_t                  wd;
        be_t                    be;
        int                     idx;
        logic                   got;
        logic [IRQ_NUM_POW-1:0] code;
        int unsigned            seed_ret;

        seed_ret  = $urandom(89);
        rst_i     = 1'b1;
        req_i     = 1'b0;
        we_i      = 1'b0;
        addr_i    = '0;
        be_i      = '0;
        wdata_i   = '0;
        irq_i     = '0;
        irq_ack_i = 1'b0;
        en_model  = '0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_value("ack_o after reset", ack_o, 0);
        check_value("irq_req_o after reset", irq_req_o, 0);

        // full-word RAM fill first so no byte stays unknown
        for (int i = 0; i < RAM_WORDS; i++)
        begin
            wd = $urandom;
            host_access(1'b1, addr_t'(i * 4), 4'hF, wd, rd);
            ram_model[i] = wd;
        end
        repeat (150)
        begin
            idx = $urandom % RAM_WORDS;
            if ($urandom % 2)
            begin
                wd = $urandom;
                be = be_t'($urandom);
                host_access(1'b1, addr_t'(idx * 4), be, wd, rd);
                ram_model[idx] = merge_bytes(ram_model[idx], wd, be);
            end
            else
            begin
                host_access(1'b0, addr_t'(idx * 4), 4'hF, '0, rd);
                check_value("rdata_o ram", rd, ram_model[idx]);
            end
        end
        for (int i = 0; i < RAM_WORDS; i++)
        begin
            host_access(1'b0, addr_t'(i * 4), 4'hF, '0, rd);
            check_value("rdata_o ram final", rd, ram_model[i]);
        end

        // SFR map
        sfr_read(SFR_CORENUM, rd);
        check_value("rdata_o corenum", rd, CORE_ID);
        sfr_read(SFR_CTRL, rd);
        check_value("rdata_o ctrl", rd, 0);
        wd = $urandom;
        sfr_write(SFR_IRQ_EN, wd);
        en_model = wd[IRQ_NUM-1:0];
        sfr_read(SFR_IRQ_EN, rd);
        check_value("rdata_o irq_en", rd, data_t'(en_model));
        // long period so it cannot fire here
        wd = $urandom | 32'h0010_0000;
        sfr_write(SFR_TIMER, wd);
        sfr_read(SFR_TIMER, rd);
        check_value("rdata_o timer", rd, wd);
        sfr_read(SFR_SGI, rd);
        check_value("rdata_o sgi", rd, 0);
        sfr_write(SFR_TIMER, '0);
        sfr_write(SFR_IRQ_EN, '0);
        en_model = '0;

        // software-generated interrupts
        repeat (8)
        begin
            idx = $urandom % IRQ_NUM;
            sfr_write(SFR_SGI, ($urandom & ~data_t'(IRQ_NUM - 1)) | data_t'(idx));
            take_irq(20, got, code);
            check_value("irq_req_o sgi", got, 1);
            check_value("irq_code_o sgi", code, idx);
            take_irq(10, got, code);
            check_value("irq_req_o after ack", got, 0);
        end

        // external edges with random enables
        repeat (6)
        begin
            wd = $urandom;
            sfr_write(SFR_IRQ_EN, wd);
            en_model = wd[IRQ_NUM-1:0];
            edge_round(IRQ_NUM'($urandom));
        end

        // timer on line 1
        en_model = IRQ_NUM'(1) << IRQ_TIMER_LINE;
        sfr_write(SFR_IRQ_EN, data_t'(en_model));
        sfr_write(SFR_TIMER, 32'd8);
        repeat (4)
        begin
            take_irq(30, got, code);
            check_value("irq_req_o timer", got, 1);
            check_value("irq_code_o timer", code, IRQ_TIMER_LINE);
        end
        sfr_write(SFR_TIMER, '0);
        repeat (3)
        begin
            take_irq(20, got, code);
            if (got)
                check_value("irq_code_o timer drain", code, IRQ_TIMER_LINE);
        end
        take_irq(60, got, code);
        check_value("irq_req_o timer off", got, 0);

        // software reset holds the adapter
        en_model = '1;
        sfr_write(SFR_IRQ_EN, data_t'(en_model));
        pulse_lines(IRQ_NUM'(1) << 5);
        sfr_write(SFR_CTRL, 32'd1);
        check_value("irq_req_o in sw reset", irq_req_o, 0);
        pulse_lines(IRQ_NUM'($urandom) | IRQ_NUM'(1));
        sfr_write(SFR_SGI, 32'd3);
        take_irq(30, got, code);
        check_value("irq_req_o in sw reset", got, 0);
        sfr_read(SFR_CTRL, rd);
        check_value("rdata_o ctrl", rd, 1);
        sfr_write(SFR_CTRL, '0);
        edge_round(IRQ_NUM'($urandom) | IRQ_NUM'(1));

        if (i_dut.i_props.fail_count != 0)
            stop_run("a handshake assertion on the tile failed");
        else
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- verification/tile_props.sv
// tile handshake properties
// bound to sigma_tile, checks the host and core four-phase pairs

`timescale 1ns/1ps

module tile_props
#(
    parameter int IRQ_NUM_POW = 4
)
(
    input  logic                     clk_i
    , input  logic                     rst_i
    , input  logic                     req_i
    , input  logic                     ack_i
    , input  logic                     irq_req_i
    , input  logic [IRQ_NUM_POW-1:0]   irq_code_i
);

    // failed property count
    int unsigned fail_count = 0;

    ack_held: assert property (@(posedge clk_i) disable iff (rst_i)
        (ack_i && req_i) |=> ack_i)
    else
    begin
        fail_count++;
        $error("ack_o dropped while req_i was still high");
    end

    // ack only answers a request already on the bus
    ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ack_i) |-> $past(req_i))
    else
    begin
        fail_count++;
        $error("ack_o rose without a request");
    end

    code_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (irq_req_i && $past(irq_req_i)) |-> $stable(irq_code_i))
    else
    begin
        fail_count++;
        $error("irq_code_o changed while irq_req_o was high");
    end

endmodule

bind sigma_tile tile_props #(
    .IRQ_NUM_POW(IRQ_NUM_POW)
) i_props (
    .clk_i          (clk_i)
    , .rst_i        (rst_i)
    , .req_i        (req_i)
    , .ack_i        (ack_o)
    , .irq_req_i    (irq_req_o)
    , .irq_code_i   (irq_code_o)
);

//--- rtl/sigma_tile.sv
// sigma tile
// host-accessible RAM and SFR block with an interrupt adapter
// that feeds an external core

`timescale 1ns/1ps

module sigma_tile
    import tile_bus_pkg::*;
    import tile_sfr_pkg::*;
#(
    parameter int MEM_SIZE         = 1024
    , parameter int CORENUM          = 0
    , parameter bit SW_RESET_DEFAULT = 1'b0
    , parameter int IRQ_NUM_POW      = 4
)
(
    input  logic  clk_i
    , input  logic  rst_i

    , input  logic  req_i
    , input  logic  we_i
    , input  addr_t addr_i
    , input  be_t   be_i
    , input  data_t wdata_i
    , output logic  ack_o
    , output data_t rdata_o

    , input  logic [2**IRQ_NUM_POW-1:0] irq_i
    , output logic                      irq_req_o
    , output logic [IRQ_NUM_POW-1:0]    irq_code_o
    , input  logic                      irq_ack_i
);

    localparam int IRQ_NUM = 2**IRQ_NUM_POW;

    logic  ram_req;
    logic  sfr_req;
    logic  bus_we;
    addr_t bus_addr;
    be_t   bus_be;
    data_t bus_wdata;
    data_t ram_rdata;
    data_t sfr_rdata;

    logic                   sw_reset;
    logic [IRQ_NUM-1:0]     irq_en;
    logic                   irq_timer;
    logic                   sgi_req;
    logic [IRQ_NUM_POW-1:0] sgi_code;
    logic [IRQ_NUM-1:0]     irq_masked;
    logic                   adapter_rst;

    // timer shares line 1 with the external source
    assign irq_masked  = (irq_i | (IRQ_NUM'(irq_timer) << IRQ_TIMER_LINE)) & irq_en;
    assign adapter_rst = rst_i || sw_reset;

    host_decode i_host_decode (
        .clk_i          (clk_i)
        , .rst_i        (rst_i)
        , .req_i        (req_i)
        , .we_i         (we_i)
        , .addr_i       (addr_i)
        , .be_i         (be_i)
        , .wdata_i      (wdata_i)
        , .ack_o        (ack_o)
        , .rdata_o      (rdata_o)
        , .ram_req_o    (ram_req)
        , .sfr_req_o    (sfr_req)
        , .we_o         (bus_we)
        , .addr_o       (bus_addr)
        , .be_o         (bus_be)
        , .wdata_o      (bus_wdata)
        , .ram_rdata_i  (ram_rdata)
        , .sfr_rdata_i  (sfr_rdata)
    );

    tile_ram #(
        .MEM_SIZE(MEM_SIZE)
    ) i_tile_ram (
        .clk_i      (clk_i)
        , .req_i    (ram_req)
        , .we_i     (bus_we)
        , .addr_i   (bus_addr)
        , .be_i     (bus_be)
        , .wdata_i  (bus_wdata)
        , .rdata_o  (ram_rdata)
    );

    tile_sfr #(
        .CORENUM            (CORENUM)
        , .SW_RESET_DEFAULT (SW_RESET_DEFAULT)
        , .IRQ_NUM_POW      (IRQ_NUM_POW)
    ) i_tile_sfr (
        .clk_i          (clk_i)
        , .rst_i        (rst_i)
        , .req_i        (sfr_req)
        , .we_i         (bus_we)
        , .addr_i       (bus_addr)
        , .wdata_i      (bus_wdata)
        , .rdata_o      (sfr_rdata)
        , .sw_reset_o   (sw_reset)
        , .irq_en_o     (irq_en)
        , .irq_timer_o  (irq_timer)
        , .sgi_req_o    (sgi_req)
        , .sgi_code_o   (sgi_code)
    );

    irq_adapter #(
        .IRQ_NUM_POW(IRQ_NUM_POW)
    ) i_irq_adapter (
        .clk_i          (clk_i)
        , .rst_i        (adapter_rst)
        , .irq_i        (irq_masked)
        , .sgi_req_i    (sgi_req)
        , .sgi_code_i   (sgi_code)
        , .irq_req_o    (irq_req_o)
        , .irq_code_o   (irq_code_o)
        , .irq_ack_i    (irq_ack_i)
    );

endmodule

//--- rtl/irq_adapter.sv
// interrupt adapter
// latches line edges and SGIs as pending and offers the lowest one
// to the core over a four-phase req/ack pair

`timescale 1ns/1ps

module irq_adapter
#(
    parameter int IRQ_NUM_POW = 4
)
(
    input  logic                      clk_i
    , input  logic                      rst_i

    , input  logic [2**IRQ_NUM_POW-1:0] irq_i
    , input  logic                      sgi_req_i
    , input  logic [IRQ_NUM_POW-1:0]    sgi_code_i

    , output logic                      irq_req_o
    , output logic [IRQ_NUM_POW-1:0]    irq_code_o
    , input  logic                      irq_ack_i
);

    localparam int IRQ_NUM = 2**IRQ_NUM_POW;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT_LOW
    } state_t;

    state_t                 state;
    logic [IRQ_NUM-1:0]     irq_prev;
    logic [IRQ_NUM-1:0]     pending;
    logic [IRQ_NUM-1:0]     set_mask;
    logic [IRQ_NUM-1:0]     clr_mask;
    logic [IRQ_NUM_POW-1:0] lowest;

    always_comb
    begin
        set_mask = irq_i & ~irq_prev;
        if (sgi_req_i)
            set_mask[sgi_code_i] = 1'b1;
        clr_mask = '0;
        if (state == ST_REQ && irq_ack_i)
            clr_mask[irq_code_o] = 1'b1;
        // scan downward so the lowest index wins
        lowest = '0;
        for (int i = IRQ_NUM - 1; i >= 0; i--)
            if (pending[i])
                lowest = IRQ_NUM_POW'(i);
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state     <= ST_IDLE;
            irq_req_o <= 1'b0;
            pending   <= '0;
            // lines already high at release are not new edges
            irq_prev  <= irq_i;
        end
        else
        begin
            irq_prev <= irq_i;
            pending  <= (pending & ~clr_mask) | set_mask;
            case (state)
                ST_IDLE:
                    if (|pending)
                    begin
                        irq_code_o <= lowest;
                        irq_req_o  <= 1'b1;
                        state      <= ST_REQ;
                    end
                ST_REQ:
                    if (irq_ack_i)
                    begin
                        irq_req_o <= 1'b0;
                        state     <= ST_WAIT_LOW;
                    end
                ST_WAIT_LOW:
                    if (!irq_ack_i)
                        state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/tile_sfr.sv
// tile SFR block
// core number, software reset, interrupt enables, periodic timer
// and software-generated interrupt trigger

`timescale 1ns/1ps

module tile_sfr
    import tile_bus_pkg::*;
    import tile_sfr_pkg::*;
#(
    parameter int CORENUM          = 0
    , parameter bit SW_RESET_DEFAULT = 1'b0
    , parameter int IRQ_NUM_POW      = 4
)
(
    input  logic  clk_i
    , input  logic  rst_i

    , input  logic  req_i
    , input  logic  we_i
    , input  addr_t addr_i
    , input  data_t wdata_i
    , output data_t rdata_o

    , output logic                       sw_reset_o
    , output logic [2**IRQ_NUM_POW-1:0]  irq_en_o
    , output logic                       irq_timer_o
    , output logic                       sgi_req_o
    , output logic [IRQ_NUM_POW-1:0]     sgi_code_o
);

    sfr_idx_t idx;
    timer_t   timer_period;
    timer_t   timer_cnt;
    logic     wr_en;

    assign idx   = addr_i[4:2];
    assign wr_en = req_i && we_i;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            sw_reset_o   <= SW_RESET_DEFAULT;
            irq_en_o     <= '0;
            timer_period <= '0;
            timer_cnt    <= '0;
            irq_timer_o  <= 1'b0;
            sgi_req_o    <= 1'b0;
        end
        else
        begin
            sgi_req_o   <= 1'b0;
            irq_timer_o <= 1'b0;

            // period 0 keeps the timer stopped
            if (timer_period == '0)
                timer_cnt <= '0;
            else if (timer_cnt >= timer_period - timer_t'(1))
            begin
                timer_cnt   <= '0;
                irq_timer_o <= 1'b1;
            end
            else
                timer_cnt <= timer_cnt + timer_t'(1);

            if (wr_en)
            begin
                case (idx)
                    SFR_CTRL:   sw_reset_o <= wdata_i[0];
                    SFR_IRQ_EN: irq_en_o   <= wdata_i[2**IRQ_NUM_POW-1:0];
                    SFR_TIMER:
                    begin
                        timer_period <= wdata_i;
                        timer_cnt    <= '0;
                    end
                    SFR_SGI:    sgi_req_o  <= 1'b1;
                    default:    ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (wr_en && idx == SFR_SGI)
            sgi_code_o <= wdata_i[IRQ_NUM_POW-1:0];
        if (req_i)
        begin
            case (idx)
                SFR_CORENUM: rdata_o <= data_t'(CORENUM);
                SFR_CTRL:    rdata_o <= data_t'(sw_reset_o);
                SFR_IRQ_EN:  rdata_o <= data_t'(irq_en_o);
                SFR_TIMER:   rdata_o <= timer_period;
                default:     rdata_o <= '0;
            endcase
        end
    end

endmodule

//--- rtl/tile_ram.sv
// tile RAM
// single-port word memory with byte enables, one cycle read latency

`timescale 1ns/1ps

module tile_ram
    import tile_bus_pkg::*;
#(
    parameter int MEM_SIZE = 1024
)
(
    input  logic  clk_i

    , input  logic  req_i
    , input  logic  we_i
    , input  addr_t addr_i
    , input  be_t   be_i
    , input  data_t wdata_i
    , output data_t rdata_o
);

    localparam int IDX_W = (MEM_SIZE > 1) ? $clog2(MEM_SIZE) : 1;

    data_t            mem [MEM_SIZE];
    logic [IDX_W-1:0] word_idx;

    // word address wraps at the array size
    assign word_idx = IDX_W'(addr_i[31:2] % MEM_SIZE);

    always_ff @(posedge clk_i)
    begin
        if (req_i)
        begin
            if (we_i)
            begin
                for (int i = 0; i < 4; i++)
                    if (be_i[i])
                        mem[word_idx][i*8 +: 8] <= wdata_i[i*8 +: 8];
            end
            rdata_o <= mem[word_idx];
        end
    end

endmodule

//--- rtl/host_decode.sv
// host decode
// runs the four-phase host handshake, strobes the RAM or the SFR block
// and hands the selected read data back with the acknowledge

`timescale 1ns/1ps

module host_decode
    import tile_bus_pkg::*;
(
    input  logic  clk_i
    , input  logic  rst_i

    , input  logic  req_i
    , input  logic  we_i
    , input  addr_t addr_i
    , input  be_t   be_i
    , input  data_t wdata_i
    , output logic  ack_o
    , output data_t rdata_o

    , output logic  ram_req_o
    , output logic  sfr_req_o
    , output logic  we_o
    , output addr_t addr_o
    , output be_t   be_o
    , output data_t wdata_o
    , input  data_t ram_rdata_i
    , input  data_t sfr_rdata_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESPOND,
        ST_RELEASE
    } state_t;

    state_t state;
    logic   sel_sfr;

    // single strobe while in access
    assign ram_req_o = (state == ST_ACCESS) && !sel_sfr;
    assign sfr_req_o = (state == ST_ACCESS) && sel_sfr;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state <= ST_IDLE;
            ack_o <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    ack_o <= 1'b0;
                    if (req_i)
                        state <= ST_ACCESS;
                end
                ST_ACCESS:
                    state <= ST_RESPOND;
                ST_RESPOND:
                begin
                    ack_o <= 1'b1;
                    state <= ST_RELEASE;
                end
                ST_RELEASE:
                begin
                    // ack drops on the edge after req is seen low
                    if (!req_i)
                        state <= ST_IDLE;
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (state == ST_IDLE && req_i)
        begin
            we_o    <= we_i;
            addr_o  <= addr_i;
            be_o    <= be_i;
            wdata_o <= wdata_i;
            sel_sfr <= addr_i[SFR_BITSEL];
        end
        if (state == ST_RESPOND)
            rdata_o <= sel_sfr ? sfr_rdata_i : ram_rdata_i;
    end

endmodule

//--- rtl/tile_sfr_pkg.sv
// tile SFR package
// register map, timer count type and fixed interrupt line numbers

package tile_sfr_pkg;

    // word index within the SFR block, address bits 4..2
    typedef logic [2:0] sfr_idx_t;

    localparam sfr_idx_t SFR_CORENUM = 3'd0;
    localparam sfr_idx_t SFR_CTRL    = 3'd1;
    localparam sfr_idx_t SFR_IRQ_EN  = 3'd2;
    localparam sfr_idx_t SFR_TIMER   = 3'd3;
    localparam sfr_idx_t SFR_SGI     = 3'd4;

    typedef logic [31:0] timer_t;

    // timer wrap is merged into this line
    localparam int IRQ_TIMER_LINE = 1;

endpackage

//--- rtl/tile_bus_pkg.sv
// tile bus package
// host bus field types and the address bit that splits RAM from SFRs

package tile_bus_pkg;

    // byte address as seen by the host
    typedef logic [31:0] addr_t;

    typedef logic [31:0] data_t;

    // one enable per byte lane
    typedef logic [3:0] be_t;

    // set selects the SFR block, clear selects the RAM
    localparam int SFR_BITSEL = 20;

endpackage
